// ==== include/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path and register file
`define CPU_DATA_W      10
`define CPU_REG_ADDR_W  3

// Instruction word layout
`define CPU_INSTR_W     16
`define CPU_IMM_W       6

// Data memory words addressed by the low bits of the ALU result
`define CPU_DMEM_DEPTH  64

`endif

// ==== rtl/isa_pkg.sv ====
`include "cpu_params.svh"

package isa_pkg;

    // Opcode takes whatever the register fields and immediate leave over
    localparam int OPCODE_W = `CPU_INSTR_W - 2 * `CPU_REG_ADDR_W - `CPU_IMM_W;

    // Codes 9 to 15 are undefined and decode as NOP
    typedef enum logic [OPCODE_W-1:0] {
        OP_NOP   = 4'd0,
        OP_ADD   = 4'd1,
        OP_SUB   = 4'd2,
        OP_AND   = 4'd3,
        OP_OR    = 4'd4,
        OP_XOR   = 4'd5,
        OP_ADDI  = 4'd6,
        OP_LOAD  = 4'd7,
        OP_STORE = 4'd8
    } opcode_e;

    // ALU function select carried into the EM stage
    typedef enum logic [2:0] {
        ALU_ADD   = 3'd0,
        ALU_SUB   = 3'd1,
        ALU_AND   = 3'd2,
        ALU_OR    = 3'd3,
        ALU_XOR   = 3'd4,
        ALU_PASSB = 3'd5
    } alu_ctrl_e;

    // ra is the first source and rb is both second source and destination
    typedef struct packed {
        opcode_e                    opcode;
        logic [`CPU_REG_ADDR_W-1:0] ra;
        logic [`CPU_REG_ADDR_W-1:0] rb;
        logic [`CPU_IMM_W-1:0]      imm;
    } instr_t;

endpackage

// ==== rtl/pipe_pkg.sv ====
`include "cpu_params.svh"

package pipe_pkg;

    localparam int DMEM_ADDR_W = $clog2(`CPU_DMEM_DEPTH);

    // Everything the EM stage needs from decode
    typedef struct packed {
        logic [`CPU_DATA_W-1:0]     alu_a;
        logic [`CPU_DATA_W-1:0]     alu_b;
        logic [`CPU_DATA_W-1:0]     store_data;
        isa_pkg::alu_ctrl_e         alu_ctrl;
        logic [`CPU_REG_ADDR_W-1:0] dest;
        logic                       reg_wb;
        logic                       mem_we;
        logic                       mem_re;
    } fd_em_t;

    // Register write-back in the current cycle
    typedef struct packed {
        logic                       valid;
        logic [`CPU_REG_ADDR_W-1:0] dest;
        logic [`CPU_DATA_W-1:0]     data;
    } wb_t;

    // Data memory write in the current cycle
    typedef struct packed {
        logic                   valid;
        logic [DMEM_ADDR_W-1:0] addr;
        logic [`CPU_DATA_W-1:0] data;
    } store_t;

endpackage

// ==== rtl/gp_regfile.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module gp_regfile (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr1,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr2,
    output logic [`CPU_DATA_W-1:0]     rdata1,
    output logic [`CPU_DATA_W-1:0]     rdata2,
    input  pipe_pkg::wb_t              wb
);

    localparam int NUM_REGS = 1 << `CPU_REG_ADDR_W;

    logic [`CPU_DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // Write-through so a dependent instruction right behind the writer needs no stall
    function automatic logic [`CPU_DATA_W-1:0] read_port(
        input logic [`CPU_REG_ADDR_W-1:0] addr
    );
        if (wb.valid && (wb.dest == addr)) begin
            return wb.data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rdata1 = read_port(raddr1);
        rdata2 = read_port(raddr2);
    end

endmodule

// ==== rtl/fd_stage.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module fd_stage (
    input  isa_pkg::instr_t            instr,
    output logic [`CPU_REG_ADDR_W-1:0] raddr1,
    output logic [`CPU_REG_ADDR_W-1:0] raddr2,
    input  logic [`CPU_DATA_W-1:0]     rdata1,
    input  logic [`CPU_DATA_W-1:0]     rdata2,
    output pipe_pkg::fd_em_t           fd_bundle
);

    localparam int EXT_W = `CPU_DATA_W - `CPU_IMM_W;

    logic [`CPU_DATA_W-1:0] imm_sext;
    logic                   use_imm;

    // Both operands come straight from the instruction fields
    assign raddr1 = instr.ra;
    assign raddr2 = instr.rb;

    assign imm_sext = {{EXT_W{instr.imm[`CPU_IMM_W-1]}}, instr.imm};

    always_comb begin
        use_imm               = 1'b0;
        fd_bundle.alu_ctrl    = isa_pkg::ALU_PASSB;
        fd_bundle.reg_wb      = 1'b0;
        fd_bundle.mem_we      = 1'b0;
        fd_bundle.mem_re      = 1'b0;

        case (instr.opcode)
            isa_pkg::OP_ADD: begin
                fd_bundle.alu_ctrl = isa_pkg::ALU_ADD;
                fd_bundle.reg_wb   = 1'b1;
            end
            isa_pkg::OP_SUB: begin
                fd_bundle.alu_ctrl = isa_pkg::ALU_SUB;
                fd_bundle.reg_wb   = 1'b1;
            end
            isa_pkg::OP_AND: begin
                fd_bundle.alu_ctrl = isa_pkg::ALU_AND;
                fd_bundle.reg_wb   = 1'b1;
            end
            isa_pkg::OP_OR: begin
                fd_bundle.alu_ctrl = isa_pkg::ALU_OR;
                fd_bundle.reg_wb   = 1'b1;
            end
            isa_pkg::OP_XOR: begin
                fd_bundle.alu_ctrl = isa_pkg::ALU_XOR;
                fd_bundle.reg_wb   = 1'b1;
            end
            isa_pkg::OP_ADDI: begin
                fd_bundle.alu_ctrl = isa_pkg::ALU_ADD;
                fd_bundle.reg_wb   = 1'b1;
                use_imm            = 1'b1;
            end
            // Address is ra + imm for both memory ops
            isa_pkg::OP_LOAD: begin
                fd_bundle.alu_ctrl = isa_pkg::ALU_ADD;
                fd_bundle.reg_wb   = 1'b1;
                fd_bundle.mem_re   = 1'b1;
                use_imm            = 1'b1;
            end
            isa_pkg::OP_STORE: begin
                fd_bundle.alu_ctrl = isa_pkg::ALU_ADD;
                fd_bundle.mem_we   = 1'b1;
                use_imm            = 1'b1;
            end
            // NOP and undefined codes leave every enable low
            default: begin
            end
        endcase

        fd_bundle.alu_a      = rdata1;
        fd_bundle.alu_b      = use_imm ? imm_sext : rdata2;
        fd_bundle.store_data = rdata2;
        fd_bundle.dest       = instr.rb;
    end

endmodule

// ==== rtl/fd_em_reg.sv ====
`timescale 1ns/1ps

module fd_em_reg (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,
    input  pipe_pkg::fd_em_t fd_bundle,
    output pipe_pkg::fd_em_t em_bundle
);

    logic kill;

    // A bubble enters EM as a no-op
    assign kill = reset || !instr_valid;

    always_ff @(posedge clk) begin
        // Operands, ALU select and destination
        em_bundle.alu_a      <= fd_bundle.alu_a;
        em_bundle.alu_b      <= fd_bundle.alu_b;
        em_bundle.store_data <= fd_bundle.store_data;
        em_bundle.alu_ctrl   <= fd_bundle.alu_ctrl;
        em_bundle.dest       <= fd_bundle.dest;

        // Enables
        if (kill) begin
            em_bundle.reg_wb <= 1'b0;
            em_bundle.mem_we <= 1'b0;
            em_bundle.mem_re <= 1'b0;
        end else begin
            em_bundle.reg_wb <= fd_bundle.reg_wb;
            em_bundle.mem_we <= fd_bundle.mem_we;
            em_bundle.mem_re <= fd_bundle.mem_re;
        end
    end

endmodule

// ==== rtl/em_stage.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module em_stage (
    input  logic             clk,
    input  logic             reset,
    input  pipe_pkg::fd_em_t em_bundle,
    output pipe_pkg::wb_t    wb,
    output pipe_pkg::store_t store
);

    localparam int ADDR_W = pipe_pkg::DMEM_ADDR_W;

    logic [`CPU_DATA_W-1:0] alu_result;
    logic [`CPU_DATA_W-1:0] load_data;
    logic [ADDR_W-1:0]      mem_addr;
    logic [`CPU_DATA_W-1:0] dmem [`CPU_DMEM_DEPTH];

    // All results wrap at the data width
    always_comb begin
        case (em_bundle.alu_ctrl)
            isa_pkg::ALU_ADD: alu_result = em_bundle.alu_a + em_bundle.alu_b;
            isa_pkg::ALU_SUB: alu_result = em_bundle.alu_a - em_bundle.alu_b;
            isa_pkg::ALU_AND: alu_result = em_bundle.alu_a & em_bundle.alu_b;
            isa_pkg::ALU_OR:  alu_result = em_bundle.alu_a | em_bundle.alu_b;
            isa_pkg::ALU_XOR: alu_result = em_bundle.alu_a ^ em_bundle.alu_b;
            default:          alu_result = em_bundle.alu_b;
        endcase
    end

    // Upper result bits are dropped, so addresses wrap around the memory
    assign mem_addr  = alu_result[ADDR_W-1:0];
    assign load_data = dmem[mem_addr];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (em_bundle.mem_we) begin
            dmem[mem_addr] <= em_bundle.store_data;
        end
    end

    always_comb begin
        wb.valid = em_bundle.reg_wb;
        wb.dest  = em_bundle.dest;
        wb.data  = em_bundle.mem_re ? load_data : alu_result;
    end

    // Mirrors the write that lands in dmem at the end of this cycle
    always_comb begin
        store.valid = em_bundle.mem_we;
        store.addr  = mem_addr;
        store.data  = em_bundle.store_data;
    end

endmodule

// ==== rtl/cpu_top.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module cpu_top (
    input  logic             clk,
    input  logic             reset,
    input  logic             instr_valid,
    input  isa_pkg::instr_t  instr,
    output pipe_pkg::wb_t    wb,
    output pipe_pkg::store_t store
);

    logic [`CPU_REG_ADDR_W-1:0] raddr1;
    logic [`CPU_REG_ADDR_W-1:0] raddr2;
    logic [`CPU_DATA_W-1:0]     rdata1;
    logic [`CPU_DATA_W-1:0]     rdata2;
    pipe_pkg::fd_em_t           fd_bundle;
    pipe_pkg::fd_em_t           em_bundle;

    // Decode and operand read
    fd_stage u_fd (
        .instr     (instr),
        .raddr1    (raddr1),
        .raddr2    (raddr2),
        .rdata1    (rdata1),
        .rdata2    (rdata2),
        .fd_bundle (fd_bundle)
    );

    // Write port is fed back from EM
    gp_regfile u_regs (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (raddr1),
        .raddr2 (raddr2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .wb     (wb)
    );

    fd_em_reg u_fd_em (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .fd_bundle   (fd_bundle),
        .em_bundle   (em_bundle)
    );

    // Execute, memory and write-back
    em_stage u_em (
        .clk       (clk),
        .reset     (reset),
        .em_bundle (em_bundle),
        .wb        (wb),
        .store     (store)
    );

endmodule

// ==== sim/tb_cpu.sv ====
`timescale 1ns/1ps
`include "cpu_params.svh"

module tb_cpu;

    localparam int DATA_W         = `CPU_DATA_W;
    localparam int REG_W          = `CPU_REG_ADDR_W;
    localparam int IMM_W          = `CPU_IMM_W;
    localparam int DEPTH          = `CPU_DMEM_DEPTH;
    localparam int ADDR_W         = pipe_pkg::DMEM_ADDR_W;
    localparam int NUM_REGS       = 1 << REG_W;
    localparam int NUM_RANDOM     = 300;
    // Directed part plus the random stream take about 400 cycles
    localparam int TIMEOUT_CYCLES = 1000;

    // One expected wb or store event due at a given cycle
    typedef struct packed {
        int                 due;
        logic               is_store;
        logic [ADDR_W-1:0]  loc;
        logic [DATA_W-1:0]  data;
    } event_t;

    logic             clk;
    logic             reset;
    logic             instr_valid;
    isa_pkg::instr_t  instr;
    pipe_pkg::wb_t    wb;
    pipe_pkg::store_t store;

    int          cycle  = 0;
    int          errors = 0;
    int          checks = 0;
    logic [31:0] lfsr   = 32'h59eb_0103;

    logic [DATA_W-1:0] model_regs [NUM_REGS];
    logic [DATA_W-1:0] model_mem [DEPTH];
    event_t            expected [$];
    string             exp_names [$];

    cpu_top u_dut (
        .clk         (clk),
        .reset       (reset),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb),
        .store       (store)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    always @(posedge clk) begin
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Checks: %0d, errors: %0d", checks, errors);
            $display("TB FAILED");
            $finish;
        end
    end

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'h8020_0003;
        end
        return state >> 1;
    endfunction

    function automatic logic [31:0] random_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr  = lfsr_next(lfsr);
            value = {value[30:0], lfsr[0]};
        end
        return value;
    endfunction

    function automatic int wrap(input int value, input int modulus);
        int m;
        m = value % modulus;
        if (m < 0) begin
            m = m + modulus;
        end
        return m;
    endfunction

    function automatic string kind_name(input logic is_store);
        if (is_store) begin
            return "store";
        end
        return "wb";
    endfunction

    function automatic isa_pkg::instr_t encode(input isa_pkg::opcode_e op, input int ra,
                                               input int rb, input int imm);
        isa_pkg::instr_t ins;
        ins.opcode = op;
        ins.ra     = ra[REG_W-1:0];
        ins.rb     = rb[REG_W-1:0];
        ins.imm    = imm[IMM_W-1:0];
        return ins;
    endfunction

    // Reference ISA model that runs each instruction in order and queues its visible event
    function automatic void execute_model(input isa_pkg::instr_t ins, input string name,
                                          input int due);
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] result;
        logic [ADDR_W-1:0] addr;
        int                imm_val;
        logic              writes_reg;
        logic              writes_mem;
        event_t            ev;
        a       = model_regs[ins.ra];
        b       = model_regs[ins.rb];
        imm_val = int'(ins.imm);
        if (imm_val >= (1 << (IMM_W - 1))) begin
            imm_val = imm_val - (1 << IMM_W);
        end
        addr       = ADDR_W'(wrap(int'(a) + imm_val, DEPTH));
        result     = '0;
        writes_reg = 1'b1;
        writes_mem = 1'b0;
        case (ins.opcode)
            isa_pkg::OP_ADD:  result = DATA_W'(wrap(int'(a) + int'(b), 1 << DATA_W));
            isa_pkg::OP_SUB:  result = DATA_W'(wrap(int'(a) - int'(b), 1 << DATA_W));
            isa_pkg::OP_AND:  result = a & b;
            isa_pkg::OP_OR:   result = a | b;
            isa_pkg::OP_XOR:  result = a ^ b;
            isa_pkg::OP_ADDI: result = DATA_W'(wrap(int'(a) + imm_val, 1 << DATA_W));
            isa_pkg::OP_LOAD: result = model_mem[addr];
            isa_pkg::OP_STORE: begin
                writes_reg = 1'b0;
                writes_mem = 1'b1;
            end
            default: writes_reg = 1'b0;
        endcase
        ev.due = due;
        if (writes_reg) begin
            model_regs[ins.rb] = result;
            ev.is_store = 1'b0;
            ev.loc      = ADDR_W'(ins.rb);
            ev.data     = result;
            expected.push_back(ev);
            exp_names.push_back(name);
        end
        if (writes_mem) begin
            model_mem[addr] = b;
            ev.is_store = 1'b1;
            ev.loc      = addr;
            ev.data     = b;
            expected.push_back(ev);
            exp_names.push_back(name);
        end
    endfunction

    // Output seen at edge k+2 belongs to the instruction driven at edge k
    task automatic issue(input isa_pkg::instr_t ins, input logic valid, input string name);
        @(posedge clk);
        instr       <= ins;
        instr_valid <= valid;
        if (valid) begin
            execute_model(ins, name, cycle + 2);
        end
    endtask

    task automatic send(input isa_pkg::opcode_e op, input int ra, input int rb, input int imm,
                        input string name);
        issue(encode(op, ra, rb, imm), 1'b1, name);
    endtask

    // Adding zero to a register shows its value on wb
    task automatic read_back(input int r, input string name);
        send(isa_pkg::OP_ADDI, r, r, 0, name);
    endtask

    task automatic compare_outputs();
        event_t exp_ev;
        event_t act_ev;
        string  name;
        logic   due_now;
        logic   got;
        got     = wb.valid || store.valid;
        due_now = (expected.size() != 0) && (expected[0].due <= cycle);
        if (due_now) begin
            exp_ev = expected.pop_front();
            name   = exp_names.pop_front();
        end
        if (got) begin
            assert (due_now) else begin
                errors++;
                $display("Output at cycle %0d when no instruction result was due", cycle);
            end
        end else begin
            assert (!due_now) else begin
                errors++;
                $display("Test %s: expected %s output never appeared at cycle %0d",
                         name, kind_name(exp_ev.is_store), cycle);
            end
        end
        if (got && due_now) begin
            act_ev.is_store = store.valid;
            act_ev.loc      = store.valid ? store.addr : ADDR_W'(wb.dest);
            act_ev.data     = store.valid ? store.data : wb.data;
            checks++;
            assert (act_ev.is_store == exp_ev.is_store && act_ev.loc == exp_ev.loc &&
                    act_ev.data == exp_ev.data) else begin
                errors++;
                $display("[ERROR] %s: expected %s loc %0d data 0x%03h, actual %s loc %0d data 0x%03h",
                         name, kind_name(exp_ev.is_store), exp_ev.loc, exp_ev.data,
                         kind_name(act_ev.is_store), act_ev.loc, act_ev.data);
            end
        end
    endtask

    // State is unknown before the first reset edge
    always @(posedge clk) begin
        if (cycle > 0) begin
            if (reset) begin
                assert (!wb.valid && !store.valid) else begin
                    errors++;
                    $display("wb or store valid during reset at cycle %0d", cycle);
                end
            end else begin
                compare_outputs();
            end
        end
    end

    task automatic latency_after_reset();
        issue(encode(isa_pkg::OP_ADDI, 0, 1, 9), 1'b0, "reset_latency");
        issue(encode(isa_pkg::OP_ADD, 1, 1, 0), 1'b0, "reset_latency");
        send(isa_pkg::OP_ADDI, 0, 1, 5, "reset_latency");
    endtask

    task automatic alu_chain();
        send(isa_pkg::OP_ADDI, 0, 2, 31, "alu_ops");
        send(isa_pkg::OP_ADDI, 0, 3, -7, "alu_ops");
        // Each of these reads the result written one cycle before
        send(isa_pkg::OP_ADD, 2, 3, 0, "alu_ops");
        send(isa_pkg::OP_SUB, 2, 3, 0, "alu_ops");
        send(isa_pkg::OP_AND, 2, 3, 0, "alu_ops");
        send(isa_pkg::OP_OR, 2, 3, 0, "alu_ops");
        send(isa_pkg::OP_XOR, 2, 3, 0, "alu_ops");
        send(isa_pkg::OP_ADDI, 0, 4, 31, "alu_ops");
        for (int i = 0; i < 6; i++) begin
            send(isa_pkg::OP_ADD, 4, 4, 0, "alu_ops");
        end
        send(isa_pkg::OP_SUB, 0, 4, 0, "alu_ops");
        send(isa_pkg::OP_XOR, 3, 4, 0, "alu_ops");
    endtask

    task automatic negative_immediates();
        send(isa_pkg::OP_ADDI, 0, 5, -32, "addi_negative");
        send(isa_pkg::OP_ADDI, 5, 5, -1, "addi_negative");
        send(isa_pkg::OP_ADDI, 1, 6, -5, "addi_negative");
        send(isa_pkg::OP_ADDI, 1, 6, -6, "addi_negative");
        send(isa_pkg::OP_ADDI, 6, 6, 2, "addi_negative");
    endtask

    task automatic store_then_load();
        send(isa_pkg::OP_ADDI, 0, 1, 10, "store_load");
        send(isa_pkg::OP_ADDI, 0, 2, -3, "store_load");
        send(isa_pkg::OP_STORE, 1, 2, 3, "store_load");
        send(isa_pkg::OP_LOAD, 1, 3, 3, "store_load");
        send(isa_pkg::OP_STORE, 1, 1, -10, "store_load");
        // Word 14 was never written
        send(isa_pkg::OP_LOAD, 1, 5, 4, "store_load");
        send(isa_pkg::OP_LOAD, 0, 4, 0, "store_load");
        send(isa_pkg::OP_ADDI, 0, 6, 31, "store_load");
        send(isa_pkg::OP_ADD, 6, 6, 0, "store_load");
        // 62 + 5 wraps to word 3
        send(isa_pkg::OP_STORE, 6, 2, 5, "store_load");
        send(isa_pkg::OP_LOAD, 0, 7, 3, "store_load");
        send(isa_pkg::OP_LOAD, 0, 7, 13, "store_load");
    endtask

    task automatic bubbles_and_nops();
        send(isa_pkg::OP_ADDI, 0, 1, 17, "bubble_nop");
        issue(encode(isa_pkg::OP_ADDI, 0, 1, 1), 1'b0, "bubble_nop");
        issue(encode(isa_pkg::OP_STORE, 0, 1, 24), 1'b0, "bubble_nop");
        send(isa_pkg::OP_NOP, 1, 1, 9, "bubble_nop");
        for (int code = 9; code < 16; code++) begin
            send(isa_pkg::opcode_e'(code[3:0]), 1, 1, 1, "bubble_nop");
        end
        read_back(1, "bubble_nop");
        send(isa_pkg::OP_LOAD, 0, 2, 24, "bubble_nop");
    endtask

    task automatic random_stream();
        logic [31:0] word;
        for (int n = 0; n < NUM_RANDOM; n++) begin
            // About one bubble in four
            if (random_bits(2) == 0) begin
                word = random_bits(16);
                issue(isa_pkg::instr_t'(word[15:0]), 1'b0, "random");
            end
            word = random_bits(16);
            issue(isa_pkg::instr_t'(word[15:0]), 1'b1, "random");
        end
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        // A valid instruction held during reset must not reach the outputs
        instr_valid = 1'b1;
        instr       = encode(isa_pkg::OP_ADDI, 0, 1, 9);
        for (int i = 0; i < NUM_REGS; i++) begin
            model_regs[i] = '0;
        end
        for (int i = 0; i < DEPTH; i++) begin
            model_mem[i] = '0;
        end
        repeat (2) @(posedge clk);
        reset       <= 1'b0;
        instr_valid <= 1'b0;

        latency_after_reset();
        alu_chain();
        negative_immediates();
        store_then_load();
        bubbles_and_nops();
        random_stream();

        issue(encode(isa_pkg::OP_NOP, 0, 0, 0), 1'b0, "drain");
        while (expected.size() != 0) begin
            @(posedge clk);
        end
        // One idle edge catches stray outputs before the summary
        @(posedge clk);
        @(negedge clk);

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// ==== project.f ====
+incdir+include
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/gp_regfile.sv
rtl/fd_stage.sv
rtl/fd_em_reg.sv
rtl/em_stage.sv
rtl/cpu_top.sv
sim/tb_cpu.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_cpu)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "TB PASSED"; then
    exit 0
fi
exit 1
